//--- list.f
+incdir+verif
hw/isaPkg.sv
hw/pipePkg.sv
hw/ctrlDecoder.sv
hw/immGen.sv
hw/regFileBypass.sv
hw/pipeReg.sv
hw/decodeStage.sv
hw/decodeTop.sv
verif/decodeTb.sv

//--- Bender.yml
package:
  name: decode_top

sources:
  - files:
      - hw/isaPkg.sv
      - hw/pipePkg.sv
      - hw/ctrlDecoder.sv
      - hw/immGen.sv
      - hw/regFileBypass.sv
      - hw/pipeReg.sv
      - hw/decodeStage.sv
      - hw/decodeTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/decodeTb.sv

//--- verif/decodeModel.svh
// ############################
// Decode reference model
// Register mirror and ISA decode rules
// ############################
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

word_t modelRegs [8];                               // Mirror of the register file

// Control bundle from the opcode table
function automatic ctrl_t modelCtrl(input word_t ins);
    ctrl_t      c;
    logic [4:0] opc;
    c   = '0;
    opc = ins[15:11];
    if (!(opc inside {HALT, NOP, J, JR, JAL, JALR, ADDI, SUBI, XORI, ANDNI,
                      BEQZ, BNEZ, ST, LD, SLBI, STU, LBI, RFMT})) begin
        c.illegal = 1'b1;                           // Nothing else may be set
        return c;
    end
    c.regWrite = opc inside {RFMT, ADDI, SUBI, XORI, ANDNI, LD, STU, LBI, SLBI, JAL, JALR};
    c.i1Fmt    = opc inside {ADDI, SUBI, XORI, ANDNI, ST, LD, STU};
    c.regDst   = (opc == RFMT);
    c.zeroExt  = opc inside {XORI, ANDNI, SLBI};
    c.jump     = opc inside {J, JR, JAL, JALR};
    c.aluSrc   = opc inside {JR, JALR};             // Register based jumps
    c.jmpLnk   = opc inside {JAL, JALR};
    c.isStu    = (opc == STU);
    c.memRead  = (opc == LD);
    c.memWrite = opc inside {ST, STU};
    return c;
endfunction

// Full expected op, registers read from the mirror
function automatic decodedOp_t modelOp(input fetchPkt_t pkt);
    decodedOp_t op;
    word_t      ins;
    ins          = pkt.instr;
    op.pc        = pkt.pc;
    op.ctrl      = modelCtrl(ins);
    op.readData1 = modelRegs[ins[7:5]];             // Rt / Rd1
    op.readData2 = modelRegs[ins[10:8]];            // Rs
    if (op.ctrl.i1Fmt) begin
        op.immVal = op.ctrl.zeroExt ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
    end else begin
        op.immVal = op.ctrl.zeroExt ? {8'b0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
    end
    if (op.ctrl.jump && op.ctrl.aluSrc) begin
        op.jumpDist = {{8{ins[7]}}, ins[7:0]};      // JR, JALR offset
    end else begin
        op.jumpDist = {{5{ins[10]}}, ins[10:0]};
    end
    if (op.ctrl.jmpLnk)      op.writeRegOut = 3'd7;
    else if (op.ctrl.isStu)  op.writeRegOut = ins[10:8];
    else if (op.ctrl.i1Fmt)  op.writeRegOut = ins[7:5];
    else if (op.ctrl.regDst) op.writeRegOut = ins[4:2];
    else                     op.writeRegOut = ins[10:8];
    return op;
endfunction

`endif

//--- verif/decodeTb.sv
// ############################
// Decode top testbench
// Random ops, writebacks, bypass and stalls vs model
// ############################
`timescale 1ns/1ns

module decodeTb
    import isaPkg::*, pipePkg::*;
;

    `include "decodeModel.svh"

    localparam int NUM_WRITES  = 24;                // Two fills plus bypass pulses
    localparam int NUM_INSTRS  = 416;               // Zero check, two random runs, bypass
    localparam int CYCLE_LIMIT = 8 * (NUM_WRITES + NUM_INSTRS) + 50;

    logic       clk;
    logic       rst;
    logic       inValid;
    logic       inReady;
    fetchPkt_t  inPkt;
    logic       wbValid;
    wbReq_t     wbReq;
    logic       outValid;
    logic       outReady;
    decodedOp_t outOp;

    logic [31:0] lfsrState;
    decodedOp_t  expQ [$];                          // Accepted and not yet delivered
    decodedOp_t  heldOp;
    logic        holdPending;
    int          wordErrs;
    int          idxErrs;
    int          ctrlErrs;
    int          bitErrs;
    int          otherErrs;
    int          cycleCount;

    decodeTop UUT (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inPkt    (inPkt),
        .wbValid  (wbValid),
        .wbReq    (wbReq),
        .outValid (outValid),
        .outReady (outReady),
        .outOp    (outOp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
            r = {r[14:0], lfsrState[0]};
        end
        return r;
    endfunction

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            wordErrs++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic checkIdx(input string name, input regIdx_t exp, input regIdx_t act);
        if (exp !== act) begin
            idxErrs++;
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkCtrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (exp !== act) begin
            ctrlErrs++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // Handshake bits
    task automatic checkBit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            bitErrs++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic checkOp(input string tag, input decodedOp_t exp, input decodedOp_t act);
        checkWord({tag, ".pc"}, exp.pc, act.pc);
        checkCtrl({tag, ".ctrl"}, exp.ctrl, act.ctrl);
        checkWord({tag, ".readData1"}, exp.readData1, act.readData1);
        checkWord({tag, ".readData2"}, exp.readData2, act.readData2);
        checkWord({tag, ".immVal"}, exp.immVal, act.immVal);
        checkWord({tag, ".jumpDist"}, exp.jumpDist, act.jumpDist);
        checkIdx({tag, ".writeRegOut"}, exp.writeRegOut, act.writeRegOut);
    endtask

    // Registered outputs are seen before the edge updates them
    always @(posedge clk) begin
        if (!rst) begin
            if (holdPending) begin
                checkBit("outValid held", 1'b1, outValid);
                if (outValid === 1'b1) begin
                    checkOp("outOp held", heldOp, outOp);
                end
            end
            holdPending = outValid && !outReady;
            heldOp      = outOp;
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    otherErrs++;
                    $display("Op delivered at %0t with none outstanding", $time);
                end else begin
                    checkOp("outOp", expQ.pop_front(), outOp);
                end
            end
            if (inValid && inReady) begin
                expQ.push_back(modelOp(inPkt));     // Mirror already holds any bypassed write
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d ops outstanding",
                     cycleCount, expQ.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic writeRegs();
        word_t val;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            val          = randBits(16);
            wbValid      = 1'b1;
            wbReq.wrSel  = regIdx_t'(i);
            wbReq.wrData = val;
            modelRegs[i] = val;
        end
        @(negedge clk);
        wbValid = 1'b0;
    endtask

    task automatic sendInstrs(input int count);
        int   sent;
        logic fired;
        sent  = 0;
        fired = 1'b0;
        while (sent < count) begin
            @(negedge clk);
            if (fired) begin
                inValid = 1'b0;
            end
            outReady = (randBits(2) != 2'b00);      // Stall roughly one cycle in four
            if (!inValid && (randBits(2) != 2'b00)) begin
                inPkt.instr = randBits(16);         // Random opcode including illegal ones
                inPkt.pc    = randBits(16);
                inValid     = 1'b1;
            end
            @(posedge clk);
            fired = inValid && inReady;
            if (fired) begin
                sent++;
            end
        end
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic drain();
        @(negedge clk);
        inValid  = 1'b0;
        outReady = 1'b1;
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Write lands on the edge where the output register reads
    task automatic bypassTest(input int count);
        regIdx_t sel;
        word_t   val;
        for (int k = 0; k < count; k++) begin
            drain();
            inPkt.instr  = randBits(16);
            inPkt.pc     = randBits(16);
            sel          = k[0] ? inPkt.instr[7:5] : inPkt.instr[10:8];
            val          = randBits(16);
            inValid      = 1'b1;
            modelRegs[sel] = val;                   // Visible through the bypass
            @(posedge clk);
            checkBit("inReady on empty pipeline", 1'b1, inReady);
            @(negedge clk);
            inValid      = 1'b0;
            wbValid      = 1'b1;
            wbReq.wrSel  = sel;
            wbReq.wrData = val;
            @(negedge clk);
            wbValid = 1'b0;
        end
        drain();
    endtask

    initial begin
        rst         = 1'b1;
        inValid     = 1'b0;
        inPkt       = '0;
        wbValid     = 1'b0;
        wbReq       = '0;
        outReady    = 1'b0;
        lfsrState   = 32'd67238;
        holdPending = 1'b0;
        heldOp      = '0;
        wordErrs    = 0;
        idxErrs     = 0;
        ctrlErrs    = 0;
        bitErrs     = 0;
        otherErrs   = 0;
        cycleCount  = 0;
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        outReady = 1'b1;
        checkBit("outValid after reset", 1'b0, outValid);
        checkBit("inReady after reset", 1'b1, inReady);
        sendInstrs(8);                              // Registers still zero
        drain();
        writeRegs();                                // Phase 1
        sendInstrs(200);                            // Phase 2
        drain();
        bypassTest(8);                              // Phase 3
        writeRegs();                                // Phase 4, new values
        sendInstrs(200);
        drain();
        $display("Errors: word %0d, index %0d, control %0d, handshake %0d, other %0d",
                 wordErrs, idxErrs, ctrlErrs, bitErrs, otherErrs);
        if (wordErrs + idxErrs + ctrlErrs + bitErrs + otherErrs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- hw/decodeTop.sv
// ############################
// Decode top
// Input register, decode stage, output register
// ############################
`timescale 1ns/1ns

module decodeTop
    import isaPkg::*, pipePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    output logic       inReady,
    input  fetchPkt_t  inPkt,
    input  logic       wbValid,
    input  wbReq_t     wbReq,
    output logic       outValid,
    input  logic       outReady,
    output decodedOp_t outOp
);

    localparam int DATA_WIDTH = $bits(word_t);

    logic       midValid;                       // Input register holds an instruction
    logic       midReady;                       // Output register can take it
    fetchPkt_t  midPkt;
    decodedOp_t decOp;

    pipeReg #(.PAYLOAD_T(fetchPkt_t)) inReg (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inPkt),
        .outValid (midValid),
        .outReady (midReady),
        .outData  (midPkt)
    );

    decodeStage #(.DATA_WIDTH(DATA_WIDTH)) decode0 (
        .clk     (clk),
        .rst     (rst),
        .pkt     (midPkt),
        .wbValid (wbValid),
        .wbReq   (wbReq),
        .op      (decOp)
    );

    pipeReg #(.PAYLOAD_T(decodedOp_t)) outReg (
        .clk      (clk),
        .rst      (rst),
        .inValid  (midValid),
        .inReady  (midReady),
        .inData   (decOp),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outOp)
    );

endmodule

//--- hw/decodeStage.sv
// ############################
// Decode stage
// Control, operand read, immediates, destination
// ############################
`timescale 1ns/1ns

module decodeStage
    import isaPkg::*, pipePkg::*;
#(
    parameter int DATA_WIDTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  fetchPkt_t  pkt,
    input  logic       wbValid,
    input  wbReq_t     wbReq,
    output decodedOp_t op
);

    ctrl_t                 ctrl;
    regIdx_t               rsIdx;
    regIdx_t               rtIdx;
    regIdx_t               rdIdx;
    logic [DATA_WIDTH-1:0] rdData1;
    logic [DATA_WIDTH-1:0] rdData2;

    assign rsIdx = pkt.instr[RS_HI:RS_LO];      // Rs in I1, I2, R-format
    assign rtIdx = pkt.instr[RT_HI:RT_LO];      // Rd in I1, Rt in R-format
    assign rdIdx = pkt.instr[RD_HI:RD_LO];      // R-format destination

    ctrlDecoder ctrlDec (
        .instr (pkt.instr),
        .ctrl  (ctrl)
    );

    // Port 1 reads Rt/Rd1, port 2 reads Rs
    regFileBypass #(.DATA_WIDTH(DATA_WIDTH)) regFile0 (
        .clk     (clk),
        .rst     (rst),
        .rdSel1  (rtIdx),
        .rdSel2  (rsIdx),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wrEn    (wbValid),
        .wrSel   (wbReq.wrSel),
        .wrData  (wbReq.wrData)
    );

    immGen immGen0 (
        .instr    (pkt.instr),
        .ctrl     (ctrl),
        .immVal   (op.immVal),
        .jumpDist (op.jumpDist)
    );

    assign op.pc        = pkt.pc;
    assign op.ctrl      = ctrl;
    assign op.readData1 = rdData1;
    assign op.readData2 = rdData2;

    // Destination priority, link first
    always_comb begin
        if (ctrl.jmpLnk)      op.writeRegOut = LINK_REG;
        else if (ctrl.isStu)  op.writeRegOut = rsIdx;     // Base register update
        else if (ctrl.i1Fmt)  op.writeRegOut = rtIdx;
        else if (ctrl.regDst) op.writeRegOut = rdIdx;
        else                  op.writeRegOut = rsIdx;     // I-format 2
    end

endmodule

//--- hw/pipeReg.sv
// ############################
// One-entry valid/ready pipeline register
// ############################
`timescale 1ns/1ns

module pipeReg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    output logic     inReady,
    input  PAYLOAD_T inData,
    output logic     outValid,
    input  logic     outReady,
    output PAYLOAD_T outData
);

    // Free when empty or when the held item leaves this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;                // Refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;                  // Payload only moves on a transfer
        end
    end

    // A stalled item must not change under the consumer
    holdStable: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outData)))
        else $error("pipeReg: payload changed while stalled");

endmodule

//--- hw/regFileBypass.sv
// ############################
// Register file, 8 entries
// Two reads, one write, write-to-read bypass
// ############################
`timescale 1ns/1ns

module regFileBypass
    import isaPkg::*;
#(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  regIdx_t               rdSel1,
    input  regIdx_t               rdSel2,
    output logic [DATA_WIDTH-1:0] rdData1,
    output logic [DATA_WIDTH-1:0] rdData2,
    input  logic                  wrEn,
    input  regIdx_t               wrSel,
    input  logic [DATA_WIDTH-1:0] wrData
);

    localparam int NUM_REGS = 2 ** $bits(regIdx_t);

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                  // All registers start at zero
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // Same-cycle write wins over the stored value
    assign rdData1 = (wrEn && (wrSel == rdSel1)) ? wrData : regs[rdSel1];
    assign rdData2 = (wrEn && (wrSel == rdSel2)) ? wrData : regs[rdSel2];

    // An X index would corrupt an unknown register and the bypass compare
    wrSelKnown: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> !$isunknown(wrSel))
        else $error("regFileBypass: write enabled with unknown index");

endmodule

//--- hw/immGen.sv
// ############################
// Immediate and jump distance generator
// ############################
`timescale 1ns/1ns

module immGen
    import isaPkg::*, pipePkg::*;
(
    input  word_t instr,
    input  ctrl_t ctrl,
    output word_t immVal,
    output word_t jumpDist
);

    localparam int W = $bits(word_t);

    word_t imm5Sx;
    word_t imm5Zx;
    word_t imm8Sx;
    word_t imm8Zx;
    word_t disp11Sx;
    word_t immSx;
    word_t immZx;

    // Extended forms of each field
    assign imm5Sx   = {{(W-IMM5_HI-1){instr[IMM5_HI]}}, instr[IMM5_HI:0]};
    assign imm5Zx   = {{(W-IMM5_HI-1){1'b0}}, instr[IMM5_HI:0]};
    assign imm8Sx   = {{(W-IMM8_HI-1){instr[IMM8_HI]}}, instr[IMM8_HI:0]};
    assign imm8Zx   = {{(W-IMM8_HI-1){1'b0}}, instr[IMM8_HI:0]};
    assign disp11Sx = {{(W-DISP_HI-1){instr[DISP_HI]}}, instr[DISP_HI:0]};

    // I1 takes the 5-bit field, everything else the 8-bit one
    assign immSx = ctrl.i1Fmt ? imm5Sx : imm8Sx;
    assign immZx = ctrl.i1Fmt ? imm5Zx : imm8Zx;

    assign immVal = ctrl.zeroExt ? immZx : immSx;

    // JR and JALR add an 8-bit offset to Rs
    assign jumpDist = (ctrl.jump && ctrl.aluSrc) ? imm8Sx : disp11Sx;

endmodule

//--- hw/ctrlDecoder.sv
// ############################
// Control decoder
// Opcode to control bundle, flags illegal opcodes
// ############################
`timescale 1ns/1ns

module ctrlDecoder
    import isaPkg::*, pipePkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[OPC_HI:OPC_LO]);

    always_comb begin
        ctrl = '0;                              // Unknown opcodes keep everything clear
        case (opcode)
            HALT, NOP, BEQZ, BNEZ: begin
                ctrl.regWrite = 1'b0;           // Legal, no register or memory effect
            end
            J: begin
                ctrl.jump = 1'b1;
            end
            JR: begin
                ctrl.jump   = 1'b1;
                ctrl.aluSrc = 1'b1;             // Offset from Rs
            end
            JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.jmpLnk   = 1'b1;
                ctrl.regWrite = 1'b1;           // Return address to R7
            end
            JALR: begin
                ctrl.jump     = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.jmpLnk   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            ADDI, SUBI: begin
                ctrl.i1Fmt    = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            XORI, ANDNI: begin
                ctrl.i1Fmt    = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.zeroExt  = 1'b1;           // Logic ops take unsigned immediates
            end
            ST: begin
                ctrl.i1Fmt    = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            LD: begin
                ctrl.i1Fmt    = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            STU: begin
                ctrl.i1Fmt    = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.regWrite = 1'b1;           // Updated base address
                ctrl.isStu    = 1'b1;
            end
            SLBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.zeroExt  = 1'b1;           // Shift then OR in low byte
            end
            LBI: begin
                ctrl.regWrite = 1'b1;
            end
            RFMT: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    // A store and a load in one op would confuse the memory stage
    memExclusive: assert final (!(ctrl.memRead && ctrl.memWrite))
        else $error("ctrlDecoder: memRead and memWrite both set for %b", instr[OPC_HI:OPC_LO]);

endmodule

//--- hw/pipePkg.sv
// ############################
// Pipeline packets around the decode stage
// ############################
package pipePkg;

    import isaPkg::*;

    // Fetched instruction, 32 bits
    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetchPkt_t;

    // Control bundle from the opcode decoder
    typedef struct packed {
        logic regWrite;                         // Writes a register
        logic regDst;                           // Rd from R-format field
        logic i1Fmt;                            // I-format 1 layout
        logic aluSrc;                           // Register based jump
        logic zeroExt;                          // Zero fill the immediate
        logic jump;                             // Any of the four jumps
        logic isStu;                            // STU writes back to Rs
        logic jmpLnk;                           // JAL or JALR
        logic memRead;
        logic memWrite;
        logic illegal;                          // Opcode not in the ISA
    } ctrl_t;

    // Writeback into the register file, 19 bits
    typedef struct packed {
        regIdx_t wrSel;
        word_t   wrData;
    } wbReq_t;

    // Everything execute needs from decode
    typedef struct packed {
        word_t   pc;
        ctrl_t   ctrl;
        word_t   readData1;                     // Rt in R-format, Rd in I1
        word_t   readData2;                     // Rs
        word_t   immVal;
        word_t   jumpDist;
        regIdx_t writeRegOut;
    } decodedOp_t;

endpackage

//--- hw/isaPkg.sv
// ############################
// ISA of the 16-bit teaching core
// Word types, opcodes and instruction field positions
// ############################
package isaPkg;

    typedef logic [15:0] word_t;                // Data and instruction word
    typedef logic [2:0]  regIdx_t;              // One of eight registers

    // Supported opcodes, anything else decodes as illegal
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        J     = 5'b00100,                       // PC relative, 11-bit displacement
        JR    = 5'b00101,                       // Register based, 8-bit offset
        JAL   = 5'b00110,
        JALR  = 5'b00111,
        ADDI  = 5'b01000,
        SUBI  = 5'b01001,
        XORI  = 5'b01010,
        ANDNI = 5'b01011,
        BEQZ  = 5'b01100,
        BNEZ  = 5'b01101,
        ST    = 5'b10000,
        LD    = 5'b10001,
        SLBI  = 5'b10010,
        STU   = 5'b10011,                       // Store with base update
        LBI   = 5'b11000,
        RFMT  = 5'b11011                        // All register-register ops
    } opcode_e;

    localparam regIdx_t LINK_REG = 3'd7;        // Return address of JAL and JALR

    /*
    Layouts
      J      opc[15:11] disp[10:0]
      I1     opc[15:11] rs[10:8] rd[7:5] imm[4:0]
      I2     opc[15:11] rs[10:8] imm[7:0]
      R      opc[15:11] rs[10:8] rt[7:5] rd[4:2] ext[1:0]
    */
    localparam int OPC_HI  = 15;
    localparam int OPC_LO  = 11;
    localparam int RS_HI   = 10;                // Rs in I1, I2 and R-format
    localparam int RS_LO   = 8;
    localparam int RT_HI   = 7;                 // Rt in R-format, Rd in I1
    localparam int RT_LO   = 5;
    localparam int RD_HI   = 4;                 // Rd of R-format
    localparam int RD_LO   = 2;
    localparam int IMM5_HI = 4;                 // I1 immediate, low end
    localparam int IMM8_HI = 7;                 // I2 immediate, low end
    localparam int DISP_HI = 10;                // J-format displacement

endpackage
